// ==== hdl/dispatch_unit.sv ====
// In-order dual issue with a pending-destination scoreboard
// No forwarding: a consumer issues after its producer's write-back edge
// Load and store share the memory unit and never pair in one cycle
`timescale 1ns/100ps
`include "dual_issue_cfg.svh"

module dispatch_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         run,
    input  dual_issue_pkg::decoded_t     dec0,
    input  dual_issue_pkg::decoded_t     dec1,
    input  dual_issue_pkg::queue_count_t count,
    output dual_issue_pkg::reg_idx_t     ra0, ra1, ra2, ra3,
    input  dual_issue_pkg::word_t        rs_data0, rs_data1, rs_data2, rs_data3,
    input  logic                         add_wb_valid,
    input  dual_issue_pkg::reg_idx_t     add_wb_rd,
    input  logic                         mul_wb_valid,
    input  dual_issue_pkg::reg_idx_t     mul_wb_rd,
    input  logic                         mem_wb_valid,
    input  dual_issue_pkg::reg_idx_t     mem_wb_rd,
    output logic [1:0]                   pop_count,
    output logic                         busy,
    output logic                         add_issue,
    output dual_issue_pkg::reg_idx_t     add_rd,
    output dual_issue_pkg::word_t        add_a, add_b,
    output logic                         mul_issue,
    output dual_issue_pkg::reg_idx_t     mul_rd,
    output dual_issue_pkg::word_t        mul_a, mul_b,
    output logic                         mem_load_issue,
    output logic                         mem_store_issue,
    output dual_issue_pkg::reg_idx_t     load_rd,
    output dual_issue_pkg::mem_addr_t    mem_addr,
    output dual_issue_pkg::word_t        store_data
);
    import dual_issue_pkg::*;

    run_state_e            state;
    logic [`REG_COUNT-1:0] pending;
    logic [`REG_COUNT-1:0] set_mask;
    logic [`REG_COUNT-1:0] clr_mask;
    logic                  valid0, valid1;
    logic                  ready0, ready1;
    logic                  pair_ok;
    logic                  go0, go1;
    logic                  add_sel, mul_sel, mem_sel;
    word_t                 addr_sum;

    // 0 means no unit needed
    function automatic logic [1:0] unit_of(op_class_e op);
        case (op)
            op_add:   return 2'd1;
            op_mul:   return 2'd2;
            op_load,
            op_store: return 2'd3;
            default:  return 2'd0;
        endcase
    endfunction

    assign ra0 = dec0.rs1;
    assign ra1 = dec0.rs2;
    assign ra2 = dec1.rs1;
    assign ra3 = dec1.rs2;

    assign valid0 = state == st_run && count != '0;
    assign valid1 = count > queue_count_t'(1);
    assign ready0 = !(pending[dec0.rs1] || pending[dec0.rs2] || pending[dec0.rd]);
    assign ready1 = !(pending[dec1.rs1] || pending[dec1.rs2] || pending[dec1.rd]);

    // Slot 1 needs its own unit and must stay clear of slot 0's destination
    assign pair_ok = (unit_of(dec1.op) == 2'd0 || unit_of(dec1.op) != unit_of(dec0.op)) &&
                     (dec0.rd == '0 || (dec1.rs1 != dec0.rd && dec1.rs2 != dec0.rd &&
                                        dec1.rd != dec0.rd));

    assign go0       = valid0 && ready0;
    assign go1       = go0 && valid1 && ready1 && pair_ok;
    assign pop_count = {1'b0, go0} + {1'b0, go1};
    assign busy      = state != st_idle;

    assign add_sel   = go1 && dec1.op == op_add;  // Slot 1 owns the adder
    assign add_issue = (go0 && dec0.op == op_add) || add_sel;
    assign add_rd    = add_sel ? dec1.rd : dec0.rd;
    assign add_a     = add_sel ? rs_data2 : rs_data0;
    assign add_b     = add_sel ? rs_data3 : rs_data1;

    assign mul_sel   = go1 && dec1.op == op_mul;
    assign mul_issue = (go0 && dec0.op == op_mul) || mul_sel;
    assign mul_rd    = mul_sel ? dec1.rd : dec0.rd;
    assign mul_a     = mul_sel ? rs_data2 : rs_data0;
    assign mul_b     = mul_sel ? rs_data3 : rs_data1;

    assign mem_sel         = go1 && (dec1.op == op_load || dec1.op == op_store);
    assign mem_load_issue  = (go0 && dec0.op == op_load) || (go1 && dec1.op == op_load);
    assign mem_store_issue = (go0 && dec0.op == op_store) || (go1 && dec1.op == op_store);
    assign load_rd         = mem_sel ? dec1.rd : dec0.rd;
    assign store_data      = mem_sel ? rs_data3 : rs_data1;
    assign addr_sum        = mem_sel ? rs_data2 + dec1.imm : rs_data0 + dec0.imm;
    assign mem_addr        = addr_sum[$bits(mem_addr_t)+1:2];  // Byte to word index

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (go0)
            set_mask[dec0.rd] = 1'b1;
        if (go1)
            set_mask[dec1.rd] = 1'b1;
        set_mask[0] = 1'b0;  // x0 never pending
        if (add_wb_valid)
            clr_mask[add_wb_rd] = 1'b1;
        if (mul_wb_valid)
            clr_mask[mul_wb_rd] = 1'b1;
        if (mem_wb_valid)
            clr_mask[mem_wb_rd] = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            pending <= '0;
        end else begin
            pending <= (pending & ~clr_mask) | set_mask;
            case (state)
                st_idle:  if (run) state <= st_run;
                st_run:   if (count == '0) state <= st_drain;
                st_drain: begin
                    if (count != '0)
                        state <= st_run;
                    else if (pending == '0)
                        state <= st_idle;
                end
                default:  state <= st_idle;
            endcase
        end
    end

endmodule

// ==== hdl/dual_issue_cfg.svh ====
// Widths, depths and latencies of the dual-issue core
// Memory is word addressed; only the low index bits of a byte address are kept
// exec_pipe and the load path need a latency of at least 2
`ifndef DUAL_ISSUE_CFG_SVH
`define DUAL_ISSUE_CFG_SVH

`define XLEN         32
`define REG_COUNT    32
`define QUEUE_DEPTH  16
`define MEM_WORDS    64
`define ADD_LATENCY  4
`define MUL_LATENCY  6
`define LOAD_LATENCY 2

`endif

// ==== hdl/dual_issue_core.sv ====
// Dual-issue core top: queue, two decoders, register file, dispatch and units
// Load the program with prog_push while idle, then hold run until busy rises
`timescale 1ns/100ps
`include "dual_issue_cfg.svh"

module dual_issue_core (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     prog_push,
    input  dual_issue_pkg::instr_t   prog_instr,
    input  logic                     run,
    input  dual_issue_pkg::reg_idx_t reg_probe_addr,
    output dual_issue_pkg::word_t    reg_probe_data,
    output logic                     busy,
    output logic                     queue_empty,
    output logic                     queue_full
);
    import dual_issue_pkg::*;

    instr_t       head0, head1;
    queue_count_t count;
    logic [1:0]   pop_count;
    decoded_t     dec0, dec1;
    reg_idx_t     ra0, ra1, ra2, ra3;
    word_t        rs_data0, rs_data1, rs_data2, rs_data3;
    logic         add_issue, mul_issue, mem_load_issue, mem_store_issue;
    reg_idx_t     add_rd, mul_rd, load_rd;
    word_t        add_a, add_b, mul_a, mul_b;
    mem_addr_t    mem_addr;
    word_t        store_data;
    logic         add_wb_valid, mul_wb_valid, mem_wb_valid;
    reg_idx_t     add_wb_rd, mul_wb_rd, mem_wb_rd;
    word_t        add_wb_data, mul_wb_data, mem_wb_data;

    instruction_queue queue0 (
        .clk(clk), .rst_n(rst_n),
        .push(prog_push), .push_instr(prog_instr), .pop_count(pop_count),
        .head0(head0), .head1(head1), .count(count),
        .empty(queue_empty), .full(queue_full)
    );

    instruction_decoder dec_slot0 (.instr(head0), .dec(dec0));
    instruction_decoder dec_slot1 (.instr(head1), .dec(dec1));

    register_file rf0 (
        .clk(clk), .rst_n(rst_n),
        .ra0(ra0), .ra1(ra1), .ra2(ra2), .ra3(ra3),
        .rd0(rs_data0), .rd1(rs_data1), .rd2(rs_data2), .rd3(rs_data3),
        .we_add(add_wb_valid), .wa_add(add_wb_rd), .wd_add(add_wb_data),
        .we_mul(mul_wb_valid), .wa_mul(mul_wb_rd), .wd_mul(mul_wb_data),
        .we_mem(mem_wb_valid), .wa_mem(mem_wb_rd), .wd_mem(mem_wb_data),
        .probe_addr(reg_probe_addr), .probe_data(reg_probe_data)
    );

    dispatch_unit dispatch0 (
        .clk(clk), .rst_n(rst_n), .run(run),
        .dec0(dec0), .dec1(dec1), .count(count),
        .ra0(ra0), .ra1(ra1), .ra2(ra2), .ra3(ra3),
        .rs_data0(rs_data0), .rs_data1(rs_data1), .rs_data2(rs_data2), .rs_data3(rs_data3),
        .add_wb_valid(add_wb_valid), .add_wb_rd(add_wb_rd),
        .mul_wb_valid(mul_wb_valid), .mul_wb_rd(mul_wb_rd),
        .mem_wb_valid(mem_wb_valid), .mem_wb_rd(mem_wb_rd),
        .pop_count(pop_count), .busy(busy),
        .add_issue(add_issue), .add_rd(add_rd), .add_a(add_a), .add_b(add_b),
        .mul_issue(mul_issue), .mul_rd(mul_rd), .mul_a(mul_a), .mul_b(mul_b),
        .mem_load_issue(mem_load_issue), .mem_store_issue(mem_store_issue),
        .load_rd(load_rd), .mem_addr(mem_addr), .store_data(store_data)
    );

    exec_pipe #(.LATENCY(`ADD_LATENCY), .IS_MUL(1'b0)) add_pipe (
        .clk(clk), .rst_n(rst_n),
        .issue(add_issue), .issue_rd(add_rd), .op_a(add_a), .op_b(add_b),
        .wb_valid(add_wb_valid), .wb_rd(add_wb_rd), .wb_data(add_wb_data)
    );

    exec_pipe #(.LATENCY(`MUL_LATENCY), .IS_MUL(1'b1)) mul_pipe (
        .clk(clk), .rst_n(rst_n),
        .issue(mul_issue), .issue_rd(mul_rd), .op_a(mul_a), .op_b(mul_b),
        .wb_valid(mul_wb_valid), .wb_rd(mul_wb_rd), .wb_data(mul_wb_data)
    );

    memory_unit mem0 (
        .clk(clk), .rst_n(rst_n),
        .load_issue(mem_load_issue), .store_issue(mem_store_issue),
        .addr(mem_addr), .store_data(store_data), .load_rd(load_rd),
        .wb_valid(mem_wb_valid), .wb_rd(mem_wb_rd), .wb_data(mem_wb_data)
    );

endmodule

// ==== hdl/dual_issue_pkg.sv ====
// Types shared by the RTL and the testbench
// decoded_t only travels from the decoders into dispatch
`include "dual_issue_cfg.svh"

package dual_issue_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [$clog2(`MEM_WORDS)-1:0] mem_addr_t;
    typedef logic [$clog2(`QUEUE_DEPTH+1)-1:0] queue_count_t;

    typedef enum logic [2:0] {
        op_nop,
        op_add,
        op_mul,
        op_load,
        op_store
    } op_class_e;

    typedef struct packed {
        op_class_e op;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        word_t     imm;  // Sign-extended I or S immediate
    } decoded_t;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_drain
    } run_state_e;

endpackage

// ==== hdl/exec_pipe.sv ====
// Fully pipelined fixed-latency ALU, add or multiply (low 32 bits)
// Result is formed at issue and shifted LATENCY stages; LATENCY >= 2
`timescale 1ns/100ps

module exec_pipe #(
    parameter int LATENCY = 4,
    parameter bit IS_MUL  = 1'b0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     issue,
    input  dual_issue_pkg::reg_idx_t issue_rd,
    input  dual_issue_pkg::word_t    op_a,
    input  dual_issue_pkg::word_t    op_b,
    output logic                     wb_valid,
    output dual_issue_pkg::reg_idx_t wb_rd,
    output dual_issue_pkg::word_t    wb_data
);
    import dual_issue_pkg::*;

    logic [LATENCY-1:0] vld;
    reg_idx_t           rd_q   [LATENCY];
    word_t              data_q [LATENCY];
    word_t              result;

    if (IS_MUL) begin : g_mul
        assign result = op_a * op_b;
    end else begin : g_add
        assign result = op_a + op_b;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            vld <= '0;
        else
            vld <= {vld[LATENCY-2:0], issue};
    end

    always_ff @(posedge clk) begin
        rd_q[0]   <= issue_rd;
        data_q[0] <= result;
        for (int i = 1; i < LATENCY; i++) begin
            rd_q[i]   <= rd_q[i-1];
            data_q[i] <= data_q[i-1];
        end
    end

    assign wb_valid = vld[LATENCY-1];
    assign wb_rd    = rd_q[LATENCY-1];
    assign wb_data  = data_q[LATENCY-1];

endmodule

// ==== hdl/instruction_decoder.sv ====
// RV32 subset decode: ADD, MUL, LW, SW; anything else is a NOP
// Fields an instruction does not use come out as x0 so they never stall
`timescale 1ns/100ps

module instruction_decoder (
    input  dual_issue_pkg::instr_t   instr,
    output dual_issue_pkg::decoded_t dec
);
    import dual_issue_pkg::*;

    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    op_class_e  op;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        op = op_nop;
        if (opcode == OPC_OP && funct3 == 3'b000 && funct7 == 7'b0000000)
            op = op_add;
        else if (opcode == OPC_OP && funct3 == 3'b000 && funct7 == 7'b0000001)
            op = op_mul;
        else if (opcode == OPC_LOAD && funct3 == 3'b010)
            op = op_load;
        else if (opcode == OPC_STORE && funct3 == 3'b010)
            op = op_store;
    end

    assign dec.op  = op;
    assign dec.rd  = (op == op_add || op == op_mul || op == op_load) ? instr[11:7] : '0;
    assign dec.rs1 = (op == op_nop) ? '0 : instr[19:15];
    assign dec.rs2 = (op == op_add || op == op_mul || op == op_store) ? instr[24:20] : '0;
    assign dec.imm = (op == op_store) ? {{20{instr[31]}}, instr[31:25], instr[11:7]} :
                     (op == op_load)  ? {{20{instr[31]}}, instr[31:20]} : '0;

endmodule

// ==== hdl/instruction_queue.sv ====
// Program FIFO, one push per cycle, up to two pops per cycle
// pop_count must never exceed count; a push to a full queue is dropped
`timescale 1ns/100ps
`include "dual_issue_cfg.svh"

module instruction_queue (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         push,
    input  dual_issue_pkg::instr_t       push_instr,
    input  logic [1:0]                   pop_count,
    output dual_issue_pkg::instr_t       head0,
    output dual_issue_pkg::instr_t       head1,
    output dual_issue_pkg::queue_count_t count,
    output logic                         empty,
    output logic                         full
);
    import dual_issue_pkg::*;

    localparam int AW = $clog2(`QUEUE_DEPTH);

    instr_t        entries [`QUEUE_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          push_ok;

    assign full    = count == queue_count_t'(`QUEUE_DEPTH);
    assign empty   = count == '0;
    assign push_ok = push && !full;
    assign head0   = entries[rd_ptr];
    assign head1   = entries[rd_ptr + 1'b1];  // Wraps with the pointer

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;
            rd_ptr <= rd_ptr + AW'(pop_count);
            count  <= count + queue_count_t'(push_ok) - queue_count_t'(pop_count);
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok)
            entries[wr_ptr] <= push_instr;
    end

endmodule

// ==== hdl/memory_unit.sv ====
// Word-addressed data memory, one load or store per cycle
// Stores land at the issue edge, loads write back LOAD_LATENCY edges later
`timescale 1ns/100ps
`include "dual_issue_cfg.svh"

module memory_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load_issue,
    input  logic                      store_issue,
    input  dual_issue_pkg::mem_addr_t addr,
    input  dual_issue_pkg::word_t     store_data,
    input  dual_issue_pkg::reg_idx_t  load_rd,
    output logic                      wb_valid,
    output dual_issue_pkg::reg_idx_t  wb_rd,
    output dual_issue_pkg::word_t     wb_data
);
    import dual_issue_pkg::*;

    word_t                    mem    [`MEM_WORDS];
    logic [`LOAD_LATENCY-1:0] vld;
    reg_idx_t                 rd_q   [`LOAD_LATENCY];
    word_t                    data_q [`LOAD_LATENCY];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem <= '{default: '0};
            vld <= '0;
        end else begin
            vld <= {vld[`LOAD_LATENCY-2:0], load_issue};
            if (store_issue)
                mem[addr] <= store_data;
        end
    end

    // Read at issue, then carry through the load pipeline
    always_ff @(posedge clk) begin
        rd_q[0]   <= load_rd;
        data_q[0] <= mem[addr];
        for (int i = 1; i < `LOAD_LATENCY; i++) begin
            rd_q[i]   <= rd_q[i-1];
            data_q[i] <= data_q[i-1];
        end
    end

    assign wb_valid = vld[`LOAD_LATENCY-1];
    assign wb_rd    = rd_q[`LOAD_LATENCY-1];
    assign wb_data  = data_q[`LOAD_LATENCY-1];

endmodule

// ==== hdl/register_file.sv ====
// Shared register file, four async read ports and three write ports
// x0 is never written; the scoreboard keeps the write indices distinct
`timescale 1ns/100ps
`include "dual_issue_cfg.svh"

module register_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  dual_issue_pkg::reg_idx_t ra0, ra1, ra2, ra3,
    output dual_issue_pkg::word_t    rd0, rd1, rd2, rd3,
    input  logic                     we_add,
    input  dual_issue_pkg::reg_idx_t wa_add,
    input  dual_issue_pkg::word_t    wd_add,
    input  logic                     we_mul,
    input  dual_issue_pkg::reg_idx_t wa_mul,
    input  dual_issue_pkg::word_t    wd_mul,
    input  logic                     we_mem,
    input  dual_issue_pkg::reg_idx_t wa_mem,
    input  dual_issue_pkg::word_t    wd_mem,
    input  dual_issue_pkg::reg_idx_t probe_addr,
    output dual_issue_pkg::word_t    probe_data
);
    import dual_issue_pkg::*;

    word_t regs [`REG_COUNT];

    assign rd0        = regs[ra0];
    assign rd1        = regs[ra1];
    assign rd2        = regs[ra2];
    assign rd3        = regs[ra3];
    assign probe_data = regs[probe_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else begin
            if (we_add && wa_add != '0)
                regs[wa_add] <= wd_add;
            if (we_mul && wa_mul != '0)
                regs[wa_mul] <= wd_mul;
            if (we_mem && wa_mem != '0)
                regs[wa_mem] <= wd_mem;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the dual-issue core testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sim.f --top-module dual_issue_tb \
        -o dual_issue_sim; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/dual_issue_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
fi

if printf '%s\n' "$sim_out" | grep -q "NO ERRORS"; then
    exit 0
fi
echo "Simulation did not pass"
exit 1

// ==== sim.f ====
+incdir+hdl
hdl/dual_issue_pkg.sv
hdl/instruction_queue.sv
hdl/instruction_decoder.sv
hdl/register_file.sv
hdl/dispatch_unit.sv
hdl/exec_pipe.sv
hdl/memory_unit.sv
hdl/dual_issue_core.sv
verif/dual_issue_properties.sv
verif/dual_issue_tb.sv

// ==== verif/dual_issue_properties.sv ====
// Concurrent checks on dispatch and on both exec pipes, attached with bind
// Ports that a target does not have are tied off, which leaves those checks idle
`timescale 1ns/100ps
`include "dual_issue_cfg.svh"

module dual_issue_properties #(
    parameter int LATENCY = 1
) (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     issue,
    input logic                     wb_valid,
    input logic                     add_issue,
    input dual_issue_pkg::reg_idx_t add_rd,
    input logic                     mul_issue,
    input dual_issue_pkg::reg_idx_t mul_rd,
    input logic                     load_issue,
    input dual_issue_pkg::reg_idx_t load_rd,
    input logic [`REG_COUNT-1:0]    pending,
    input logic                     busy
);

    // Write-back lands exactly LATENCY edges after issue
    latency_check: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid == $past(issue, LATENCY))
        else $error("wb_valid does not follow issue by %0d cycles", LATENCY);

    // Destination as routed to each unit, after the slot select
    add_rd_free: assert property (@(posedge clk) disable iff (!rst_n)
        add_issue |-> (add_rd == 5'd0 || !pending[add_rd]))
        else $error("Adder issued to x%0d while it is pending", add_rd);

    mul_rd_free: assert property (@(posedge clk) disable iff (!rst_n)
        mul_issue |-> (mul_rd == 5'd0 || !pending[mul_rd]))
        else $error("Multiplier issued to x%0d while it is pending", mul_rd);

    load_rd_free: assert property (@(posedge clk) disable iff (!rst_n)
        load_issue |-> (load_rd == 5'd0 || !pending[load_rd]))
        else $error("Load issued to x%0d while it is pending", load_rd);

    reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !busy)
        else $error("busy is high right after reset");

endmodule

bind exec_pipe dual_issue_properties #(.LATENCY(LATENCY)) pipe_props (
    .clk(clk), .rst_n(rst_n), .issue(issue), .wb_valid(wb_valid),
    .add_issue(1'b0), .add_rd('0), .mul_issue(1'b0), .mul_rd('0),
    .load_issue(1'b0), .load_rd('0), .pending('0), .busy(1'b0)
);

bind dispatch_unit dual_issue_properties dispatch_props (
    .clk(clk), .rst_n(rst_n), .issue(1'b0), .wb_valid(1'b0),
    .add_issue(add_issue), .add_rd(add_rd), .mul_issue(mul_issue), .mul_rd(mul_rd),
    .load_issue(mem_load_issue), .load_rd(load_rd), .pending(pending), .busy(busy)
);

// ==== verif/dual_issue_tb.sv ====
// Directed and random programs for the dual-issue core, checked against a sequential model
// Registers and memory reset to zero and no instruction builds a constant, so every data
// value stays zero; the tests mostly check ordering, completion and the status outputs
`timescale 1ns/100ps
`include "dual_issue_cfg.svh"

module dual_issue_tb;
    import dual_issue_pkg::*;

    localparam int         TIMEOUT = 2000;  // Cycles per wait
    localparam logic [6:0] F7_ADD  = 7'h00;
    localparam logic [6:0] F7_MUL  = 7'h01;
    localparam logic [6:0] F7_SUB  = 7'h20;  // Not supported, retires as a NOP
    localparam instr_t     NOP     = 32'h0000_0013;

    logic     clk;
    logic     rst_n;
    logic     prog_push;
    instr_t   prog_instr;
    logic     run;
    reg_idx_t reg_probe_addr;
    word_t    reg_probe_data;
    logic     busy;
    logic     queue_empty;
    logic     queue_full;

    instr_t   prog [$];
    word_t    model_regs [`REG_COUNT];
    word_t    model_mem  [`MEM_WORDS];
    bit       fail_reported;
    bit       pass_reported;

    dual_issue_core dut0 (
        .clk(clk), .rst_n(rst_n),
        .prog_push(prog_push), .prog_instr(prog_instr), .run(run),
        .reg_probe_addr(reg_probe_addr), .reg_probe_data(reg_probe_data),
        .busy(busy), .queue_empty(queue_empty), .queue_full(queue_full)
    );

    always #4 clk = ~clk;

    function automatic instr_t enc_rtype(logic [6:0] funct7, reg_idx_t rd, reg_idx_t rs1,
                                         reg_idx_t rs2);
        return {funct7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic instr_t enc_lw(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic instr_t enc_sw(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // Sequential ISA interpreter over the model state
    function automatic void run_reference();
        instr_t   ins;
        reg_idx_t rd, rs1, rs2;
        word_t    addr;
        foreach (prog[i]) begin
            ins = prog[i];
            rd  = ins[11:7];
            rs1 = ins[19:15];
            rs2 = ins[24:20];
            if (ins[6:0] == 7'h33 && ins[14:12] == 3'h0 && ins[31:25] == F7_ADD) begin
                model_regs[rd] = model_regs[rs1] + model_regs[rs2];
            end else if (ins[6:0] == 7'h33 && ins[14:12] == 3'h0 && ins[31:25] == F7_MUL) begin
                model_regs[rd] = model_regs[rs1] * model_regs[rs2];
            end else if (ins[6:0] == 7'h03 && ins[14:12] == 3'h2) begin
                addr = model_regs[rs1] + {{20{ins[31]}}, ins[31:20]};
                model_regs[rd] = model_mem[(addr >> 2) % `MEM_WORDS];
            end else if (ins[6:0] == 7'h23 && ins[14:12] == 3'h2) begin
                addr = model_regs[rs1] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                model_mem[(addr >> 2) % `MEM_WORDS] = model_regs[rs2];
            end
            model_regs[0] = '0;
        end
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run();
        fail_reported = 1'b1;
        $display("ERRORS FOUND");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic check_word(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic wait_busy(logic level);
        int cycles;
        cycles = 0;
        while (busy !== level) begin
            if (cycles == TIMEOUT) begin
                $display("Timed out after %0d cycles waiting for busy to become %0b",
                         TIMEOUT, level);
                abort_run();
            end
            next_cycle();
            cycles++;
        end
    endtask

    task automatic load_and_run();
        if (prog.size() > `QUEUE_DEPTH) begin
            $display("Program of %0d words does not fit the queue", prog.size());
            abort_run();
        end
        foreach (prog[i]) begin
            prog_push  = 1'b1;
            prog_instr = prog[i];
            next_cycle();
        end
        prog_push = 1'b0;
        check_flag("queue_full", queue_full, prog.size() == `QUEUE_DEPTH);
        check_flag("queue_empty", queue_empty, prog.size() == 0);
        run = 1'b1;
        wait_busy(1'b1);
        run = 1'b0;  // Drop before completion so the core stays idle
        wait_busy(1'b0);
    endtask

    // Probe every register on the falling edge, away from the write-back edge
    task automatic compare_registers(string tag);
        string name;
        for (int i = 0; i < `REG_COUNT; i++) begin
            reg_probe_addr = reg_idx_t'(i);
            @(negedge clk);
            name = $sformatf("%s x%0d", tag, i);
            check_word(name, reg_probe_data, model_regs[i]);
            next_cycle();
        end
        check_flag("busy", busy, 1'b0);
        check_flag("queue_empty", queue_empty, 1'b1);
        check_flag("queue_full", queue_full, 1'b0);
    endtask

    task automatic run_test(string tag);
        load_and_run();
        run_reference();
        compare_registers(tag);
    endtask

    task automatic build_random_program();
        int          kind;
        reg_idx_t    rd, rs1, rs2;
        logic [11:0] imm;
        prog.delete();
        repeat (12) begin
            kind = $urandom_range(5);
            rd   = reg_idx_t'($urandom_range(7));
            rs1  = reg_idx_t'($urandom_range(7));
            rs2  = reg_idx_t'($urandom_range(7));
            imm  = 12'($urandom_range(7) * 4);  // One of eight words
            case (kind)
                0:       prog.push_back(enc_rtype(F7_ADD, rd, rs1, rs2));
                1:       prog.push_back(enc_rtype(F7_MUL, rd, rs1, rs2));
                2:       prog.push_back(enc_lw(rd, rs1, imm));
                3:       prog.push_back(enc_sw(rs2, rs1, imm));
                4:       prog.push_back(NOP);
                default: prog.push_back(enc_rtype(F7_SUB, rd, rs1, rs2));
            endcase
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        prog_push      = 1'b0;
        prog_instr     = '0;
        run            = 1'b0;
        reg_probe_addr = '0;
        fail_reported  = 1'b0;
        pass_reported  = 1'b0;
        void'($urandom(27917));
        foreach (model_regs[i])
            model_regs[i] = '0;
        foreach (model_mem[i])
            model_mem[i] = '0;

        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        compare_registers("reset");

        // Independent ADD and MUL reach the head together
        prog = '{enc_lw(5'd1, 5'd0, 12'd8), enc_rtype(F7_ADD, 5'd2, 5'd0, 5'd0),
                 enc_rtype(F7_ADD, 5'd3, 5'd1, 5'd2), enc_rtype(F7_MUL, 5'd4, 5'd2, 5'd1)};
        run_test("pair");

        prog = '{enc_rtype(F7_MUL, 5'd6, 5'd3, 5'd4), enc_rtype(F7_ADD, 5'd7, 5'd6, 5'd1),
                 enc_rtype(F7_MUL, 5'd8, 5'd7, 5'd7)};
        run_test("raw");

        // WAW on x9 then WAR on x9 against the load
        prog = '{enc_rtype(F7_MUL, 5'd9, 5'd1, 5'd2), enc_rtype(F7_ADD, 5'd9, 5'd3, 5'd4),
                 enc_rtype(F7_ADD, 5'd10, 5'd9, 5'd1), enc_lw(5'd9, 5'd0, 12'd4)};
        run_test("waw_war");

        prog = '{enc_sw(5'd9, 5'd0, 12'd12), enc_lw(5'd11, 5'd0, 12'd12), NOP,
                 enc_rtype(F7_SUB, 5'd11, 5'd9, 5'd10), 32'hFFFF_FFFF, enc_lw(5'd12, 5'd11, 12'd12)};
        run_test("mem_nop");

        prog.delete();
        for (int i = 0; i < `QUEUE_DEPTH; i++)
            prog.push_back((i % 2 == 0) ? NOP : enc_rtype(F7_ADD, reg_idx_t'(i), 5'd1, 5'd2));
        run_test("full_queue");

        for (int n = 0; n < 10; n++) begin
            build_random_program();
            run_test($sformatf("random%0d", n));
        end

        pass_reported = 1'b1;
        $display("NO ERRORS");
        $finish;
    end

    // Covers a run stopped by a failed assertion
    final begin
        if (!pass_reported && !fail_reported)
            $display("ERRORS FOUND");
    end

endmodule
